// File: tb.f
hdl/lsu_pkg.sv
hdl/lsu_if.sv
hdl/lsu_agu.sv
hdl/lsu_data_ram.sv
hdl/lsu_load_format.sv
hdl/lsu_top.sv
tests/lsu_checker.sv
tests/tb_lsu.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_lsu
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
RUN_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu
    import lsu_pkg::*;
();

    localparam int ADDR_W = 6;
    localparam int MEM_BYTES = 2 ** ADDR_W;
    localparam int WORDS = MEM_BYTES / BYTES;
    localparam int N_RAND = 200;
    // init, random, misaligned, exception register, wrap
    localparam int N_OPS = 2 * WORDS + N_RAND + 8 + 5 + 16;
    localparam int CYCLE_LIMIT = 2 * N_OPS + 200;

    typedef struct {
        op_e op;
        exc_e exc;
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] addr;
        int cyc;
    } rec_t;

    logic clk = 1'b0;
    logic rst;
    logic req_valid_i;
    op_e req_op_i;
    size_e req_size_i;
    logic req_uext_i;
    logic [DATA_W-1:0] base_i;
    logic [DATA_W-1:0] imm_i;
    logic [DATA_W-1:0] wdata_i;
    logic exc_clr_i;
    logic wb_valid_o;
    op_e wb_op_o;
    exc_e wb_exc_o;
    logic [DATA_W-1:0] wb_data_o;
    logic exc_valid_o;
    logic [ADDR_W-1:0] exc_vaddr_o;

    logic [7:0] mem_model [MEM_BYTES];
    rec_t exp_q [$];
    logic exc_valid_m = 1'b0;
    logic [ADDR_W-1:0] exc_vaddr_m = '0;
    int seed = 56;
    int cycle = 0;
    int checks = 0;
    int errors = 0;
    int test_start = 0;

    lsu_top #(.ADDR_W(ADDR_W)) i_lsu_top (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, write-backs still missing", cycle);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got %h expected %h at cycle %0d", name, got, exp, cycle);
        end
    endtask

    function automatic int size_bytes(input size_e sz);
        case (sz)
            SIZE_B: return 1;
            SIZE_H: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] expect_load(input int a, input int n,
                                                      input logic uext);
        logic [DATA_W-1:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[8*i +: 8] = mem_model[a + i];
        end
        // sign fill above the top loaded byte
        for (int i = 8 * n; i < DATA_W; i++) begin
            val[i] = !uext && val[8*n-1];
        end
        return val;
    endfunction

    task automatic issue(input op_e op, input size_e sz, input logic uext,
                         input logic [DATA_W-1:0] base, input logic [DATA_W-1:0] imm,
                         input logic [DATA_W-1:0] wdata);
        rec_t rec;
        int a;
        int n;
        @(negedge clk);
        a = int'((base + imm) % MEM_BYTES);
        n = size_bytes(sz);
        rec.op = op;
        rec.addr = ADDR_W'(a);
        rec.cyc = cycle + 3;
        rec.data = '0;
        rec.exc = EXC_NONE;
        if (a % n != 0) begin
            rec.exc = (op == OP_LOAD) ? EXC_LAM : EXC_SAM;
        end else if (op == OP_LOAD) begin
            rec.data = expect_load(a, n, uext);
        end else begin
            for (int i = 0; i < n; i++) begin
                mem_model[a + i] = wdata[8*i +: 8];
            end
        end
        req_valid_i = 1'b1;
        req_op_i = op;
        req_size_i = sz;
        req_uext_i = uext;
        base_i = base;
        imm_i = imm;
        wdata_i = wdata;
        exp_q.push_back(rec);
    endtask

    task automatic drain();
        @(negedge clk);
        req_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // let the monitor finish the last record
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        drain();
        $display("test %s done, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    task automatic clear_exc();
        @(negedge clk);
        exc_clr_i = 1'b1;
        @(negedge clk);
        exc_clr_i = 1'b0;
        exc_valid_m = 1'b0;
    endtask

    task automatic check_exc();
        check("exc_valid_o", DATA_W'(exc_valid_o), DATA_W'(exc_valid_m));
        if (exc_valid_m) begin
            check("exc_vaddr_o", DATA_W'(exc_vaddr_o), DATA_W'(exc_vaddr_m));
        end
    endtask

    always @(negedge clk) begin : monitor
        rec_t rec;
        if (rst && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("write-back seen with no request outstanding at cycle %0d", cycle);
            end else begin
                rec = exp_q.pop_front();
                check("wb latency", DATA_W'(cycle), DATA_W'(rec.cyc));
                check("wb_op_o", DATA_W'(wb_op_o), DATA_W'(rec.op));
                check("wb_exc_o", DATA_W'(wb_exc_o), DATA_W'(rec.exc));
                check("wb_data_o", wb_data_o, rec.data);
                // first fault wins until cleared
                if (rec.exc != EXC_NONE && !exc_valid_m) begin
                    exc_valid_m = 1'b1;
                    exc_vaddr_m = rec.addr;
                end
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] base;
        int a;
        size_e sz;
        rst = 1'b1;
        req_valid_i = 1'b0;
        req_op_i = OP_LOAD;
        req_size_i = SIZE_B;
        req_uext_i = 1'b0;
        base_i = '0;
        imm_i = '0;
        wdata_i = '0;
        exc_clr_i = 1'b0;
        #2 rst = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b1;

        for (int w = 0; w < WORDS; w++) begin
            issue(OP_STORE, SIZE_W, 1'b0, 32'(4 * w), '0, $random(seed));
        end
        for (int w = 0; w < WORDS; w++) begin
            issue(OP_LOAD, SIZE_W, 1'b0, '0, 32'(4 * w), '0);
        end
        end_test("init");

        for (int k = 0; k < N_RAND; k++) begin
            rnd = $random(seed);
            sz = (rnd[3:2] == 2'd0) ? SIZE_B : (rnd[3:2] == 2'd1) ? SIZE_H : SIZE_W;
            a = int'(rnd[31:16] % MEM_BYTES);
            a = a - (a % size_bytes(sz));
            base = $random(seed);
            issue(rnd[0] ? OP_STORE : OP_LOAD, sz, rnd[1], base, 32'(a) - base, $random(seed));
        end
        end_test("random");

        // each faulting store is followed by a load of its word
        issue(OP_LOAD, SIZE_H, 1'b0, 32'd5, '0, '0);
        issue(OP_LOAD, SIZE_W, 1'b0, 32'd10, '0, '0);
        issue(OP_STORE, SIZE_W, 1'b0, 32'd13, '0, 32'hdead_beef);
        issue(OP_LOAD, SIZE_W, 1'b0, 32'd12, '0, '0);
        issue(OP_STORE, SIZE_H, 1'b0, 32'd21, '0, 32'h0000_a5a5);
        issue(OP_LOAD, SIZE_W, 1'b0, 32'd20, '0, '0);
        issue(OP_STORE, SIZE_W, 1'b0, 32'd34, '0, 32'h1234_5678);
        issue(OP_LOAD, SIZE_W, 1'b0, 32'd32, '0, '0);
        end_test("misaligned");

        clear_exc();
        check_exc();
        issue(OP_LOAD, SIZE_H, 1'b0, 32'd7, '0, '0);
        issue(OP_STORE, SIZE_W, 1'b0, 32'd9, '0, '0);
        issue(OP_LOAD, SIZE_W, 1'b0, 32'd18, '0, '0);
        drain();
        check_exc();
        check("exc_vaddr_o", DATA_W'(exc_vaddr_o), 32'd7);
        issue(OP_STORE, SIZE_H, 1'b0, 32'd41, '0, '0);
        drain();
        check("exc_vaddr_o", DATA_W'(exc_vaddr_o), 32'd7);
        clear_exc();
        check("exc_valid_o", DATA_W'(exc_valid_o), 32'd0);
        issue(OP_LOAD, SIZE_W, 1'b0, 32'd50, '0, '0);
        drain();
        check_exc();
        check("exc_vaddr_o", DATA_W'(exc_vaddr_o), 32'd50);
        end_test("exception register");

        for (int k = 0; k < 8; k++) begin
            issue(OP_STORE, SIZE_W, 1'b0, 32'(MEM_BYTES - 4), 32'(8 * k + 4), $random(seed));
            issue(OP_LOAD, SIZE_W, 1'b0, 32'hffff_fff0, 32'(8 * k + 16), '0);
        end
        end_test("address wrap");

        errors += i_lsu_top.i_lsu_checker.fail_cnt;
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tests/lsu_checker.sv
`timescale 1ns/100ps

module lsu_checker
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input logic clk,
    input logic rst,
    input logic exc_clr_i,
    input logic wb_valid_o,
    input op_e wb_op_o,
    input exc_e wb_exc_o,
    input logic [DATA_W-1:0] wb_data_o,
    input logic exc_valid_o,
    input logic [ADDR_W-1:0] exc_vaddr_o
);

    int fail_cnt = 0;

    assert property (@(posedge clk)
        !rst |-> !wb_valid_o && wb_op_o == OP_LOAD && wb_exc_o == EXC_NONE
            && wb_data_o == '0 && !exc_valid_o && exc_vaddr_o == '0)
        else begin
            fail_cnt++;
            $error("write-back or exception output active during reset");
        end

    // faulting records carry no data
    assert property (@(posedge clk) disable iff (!rst)
        wb_data_o != '0 |-> wb_exc_o == EXC_NONE)
        else begin
            fail_cnt++;
            $error("write-back data non-zero on a record with an exception");
        end

    assert property (@(posedge clk) disable iff (!rst)
        exc_clr_i |=> !exc_valid_o)
        else begin
            fail_cnt++;
            $error("exception register still valid after clear");
        end

endmodule

bind lsu_top lsu_checker #(.ADDR_W(ADDR_W)) i_lsu_checker (
    .clk(clk),
    .rst(rst),
    .exc_clr_i(exc_clr_i),
    .wb_valid_o(wb_valid_o),
    .wb_op_o(wb_op_o),
    .wb_exc_o(wb_exc_o),
    .wb_data_o(wb_data_o),
    .exc_valid_o(exc_valid_o),
    .exc_vaddr_o(exc_vaddr_o)
);

// File: hdl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input logic clk,
    input logic rst,
    input logic req_valid_i,
    input op_e req_op_i,
    input size_e req_size_i,
    input logic req_uext_i,
    input logic [DATA_W-1:0] base_i,
    input logic [DATA_W-1:0] imm_i,
    input logic [DATA_W-1:0] wdata_i,
    input logic exc_clr_i,
    output logic wb_valid_o,
    output op_e wb_op_o,
    output exc_e wb_exc_o,
    output logic [DATA_W-1:0] wb_data_o,
    output logic exc_valid_o,
    output logic [ADDR_W-1:0] exc_vaddr_o
);

    mem_req_if #(.ADDR_W(ADDR_W)) req_if ();
    ram_rsp_if #(.ADDR_W(ADDR_W)) rsp_if ();

    lsu_agu #(
        .ADDR_W(ADDR_W)
    ) i_lsu_agu (
        .clk(clk),
        .rst(rst),
        .req_valid_i(req_valid_i),
        .req_op_i(req_op_i),
        .req_size_i(req_size_i),
        .req_uext_i(req_uext_i),
        .base_i(base_i),
        .imm_i(imm_i),
        .wdata_i(wdata_i),
        .req(req_if.agu)
    );

    lsu_data_ram #(
        .ADDR_W(ADDR_W)
    ) i_lsu_data_ram (
        .clk(clk),
        .rst(rst),
        .req(req_if.ram),
        .rsp(rsp_if.ram)
    );

    lsu_load_format #(
        .ADDR_W(ADDR_W)
    ) i_lsu_load_format (
        .clk(clk),
        .rst(rst),
        .rsp(rsp_if.fmt),
        .exc_clr_i(exc_clr_i),
        .wb_valid_o(wb_valid_o),
        .wb_op_o(wb_op_o),
        .wb_exc_o(wb_exc_o),
        .wb_data_o(wb_data_o),
        .exc_valid_o(exc_valid_o),
        .exc_vaddr_o(exc_vaddr_o)
    );

endmodule

// File: hdl/lsu_load_format.sv
`timescale 1ns/100ps

module lsu_load_format
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input logic clk,
    input logic rst,
    ram_rsp_if.fmt rsp,
    input logic exc_clr_i,
    output logic wb_valid_o,
    output op_e wb_op_o,
    output exc_e wb_exc_o,
    output logic [DATA_W-1:0] wb_data_o,
    output logic exc_valid_o,
    output logic [ADDR_W-1:0] exc_vaddr_o
);

    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] load_data;
    logic has_exc;
    logic wb_data_en;
    logic exc_capture;

    // bring the addressed byte down to lane 0
    assign shifted = rsp.rdata >> {rsp.offset, 3'b000};

    always_comb begin
        case (rsp.size)
            SIZE_B: begin
                load_data = {{(DATA_W-8){~rsp.uext & shifted[7]}}, shifted[7:0]};
            end
            SIZE_H: begin
                load_data = {{(DATA_W-16){~rsp.uext & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                load_data = shifted;
            end
        endcase
    end

    assign has_exc = (rsp.exc != EXC_NONE);
    assign wb_data_en = (rsp.op == OP_LOAD) && !has_exc;

    // only the first fault is kept until software clears it
    assign exc_capture = rsp.valid && has_exc && !exc_valid_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wb_valid_o <= 1'b0;
            wb_op_o <= OP_LOAD;
            wb_exc_o <= EXC_NONE;
            wb_data_o <= '0;
        end else begin
            wb_valid_o <= rsp.valid;
            if (rsp.valid) begin
                wb_op_o <= rsp.op;
                wb_exc_o <= rsp.exc;
                wb_data_o <= wb_data_en ? load_data : '0;
            end else begin
                wb_exc_o <= EXC_NONE;
                wb_data_o <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exc_valid_o <= 1'b0;
            exc_vaddr_o <= '0;
        end else if (exc_clr_i) begin
            exc_valid_o <= 1'b0;
        end else if (exc_capture) begin
            exc_valid_o <= 1'b1;
            exc_vaddr_o <= rsp.addr;
        end
    end

endmodule

// File: hdl/lsu_data_ram.sv
`timescale 1ns/100ps

module lsu_data_ram
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input logic clk,
    input logic rst,
    mem_req_if.ram req,
    ram_rsp_if.ram rsp
);

    localparam int WORDS = 2 ** (ADDR_W - OFS_W);

    logic [DATA_W-1:0] mem [WORDS];
    logic [ADDR_W-OFS_W-1:0] word_idx;
    logic wr_en;

    assign word_idx = req.addr[ADDR_W-1:OFS_W];

    // mask is already zero for misaligned stores
    assign wr_en = req.valid && (req.op == OP_STORE);

    // read returns the old word so a store only shows in later loads
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < BYTES; i++) begin
                if (req.mask[i]) begin
                    mem[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
        if (req.valid) begin
            rsp.rdata <= mem[word_idx];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= req.valid;
        end
    end

    // fields carried along for the formatter
    always_ff @(posedge clk) begin
        rsp.op <= req.op;
        rsp.addr <= req.addr;
        rsp.offset <= req.addr[OFS_W-1:0];
        rsp.size <= req.size;
        rsp.uext <= req.uext;
        rsp.exc <= req.exc;
    end

endmodule

// File: hdl/lsu_agu.sv
`timescale 1ns/100ps

module lsu_agu
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input logic clk,
    input logic rst,
    input logic req_valid_i,
    input op_e req_op_i,
    input size_e req_size_i,
    input logic req_uext_i,
    input logic [DATA_W-1:0] base_i,
    input logic [DATA_W-1:0] imm_i,
    input logic [DATA_W-1:0] wdata_i,
    mem_req_if.agu req
);

    logic [DATA_W-1:0] sum;
    logic [ADDR_W-1:0] addr;
    logic [OFS_W-1:0] ofs;
    logic misalign;
    logic [BYTES-1:0] mask_base;
    logic [BYTES-1:0] mask;
    exc_e exc;
    logic [OFS_W-1:0] lane_src;
    logic [DATA_W-1:0] wdata_rot;

    // wraps at the top of the address range
    assign sum = base_i + imm_i;
    assign addr = sum[ADDR_W-1:0];
    assign ofs = addr[OFS_W-1:0];

    always_comb begin
        case (req_size_i)
            SIZE_H: begin
                misalign = ofs[0];
                mask_base = BYTES'(4'b0011);
            end
            SIZE_W: begin
                misalign = |ofs;
                mask_base = '1;
            end
            default: begin
                misalign = 1'b0;
                mask_base = BYTES'(4'b0001);
            end
        endcase
    end

    // a misaligned access touches no byte
    assign mask = misalign ? '0 : mask_base << ofs;

    always_comb begin
        if (!misalign) begin
            exc = EXC_NONE;
        end else if (req_op_i == OP_LOAD) begin
            exc = EXC_LAM;
        end else begin
            exc = EXC_SAM;
        end
    end

    // low store bytes move up into the lanes picked by the mask
    always_comb begin
        lane_src = '0;
        for (int i = 0; i < BYTES; i++) begin
            lane_src = OFS_W'(i) - ofs;
            wdata_rot[8*i +: 8] = wdata_i[8*lane_src +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        req.op <= req_op_i;
        req.addr <= addr;
        req.size <= req_size_i;
        req.uext <= req_uext_i;
        req.mask <= mask;
        req.wdata <= wdata_rot;
        req.exc <= exc;
    end

endmodule

// File: hdl/lsu_if.sv
`timescale 1ns/100ps

// registered request from agu to data ram
interface mem_req_if
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 6
) ();

    logic valid;
    op_e op;
    logic [ADDR_W-1:0] addr;
    size_e size;
    logic uext;
    logic [BYTES-1:0] mask;
    logic [DATA_W-1:0] wdata;
    exc_e exc;

    modport agu (output valid, op, addr, size, uext, mask, wdata, exc);
    modport ram (input valid, op, addr, size, uext, mask, wdata, exc);

endinterface

// ram read word plus the fields the formatter needs
interface ram_rsp_if
    import lsu_pkg::*;
#(
    parameter int ADDR_W = 6
) ();

    logic valid;
    op_e op;
    logic [ADDR_W-1:0] addr;
    logic [OFS_W-1:0] offset;
    size_e size;
    logic uext;
    exc_e exc;
    logic [DATA_W-1:0] rdata;

    modport ram (output valid, op, addr, offset, size, uext, exc, rdata);
    modport fmt (input valid, op, addr, offset, size, uext, exc, rdata);

endinterface

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    localparam int DATA_W = 32;
    localparam int BYTES = DATA_W / 8;
    localparam int OFS_W = $clog2(BYTES);

    // byte, half and word accesses only
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } size_e;

    typedef enum logic {
        OP_LOAD = 1'b0,
        OP_STORE = 1'b1
    } op_e;

    // misaligned load / store
    typedef enum logic [1:0] {
        EXC_NONE = 2'b00,
        EXC_LAM = 2'b01,
        EXC_SAM = 2'b10
    } exc_e;

endpackage
